// ==== include/fpu_defines.svh ====
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

`define FPU_OP_W		5
`define FPU_XLEN		32
`define FPU_BIAS		127
`define FPU_QNAN		32'h7fc00000

// Operation codes
`define FPU_OP_MOV			5'd0
`define FPU_OP_SGNJ			5'd1
`define FPU_OP_SGNJN		5'd2
`define FPU_OP_SGNJX		5'd3
`define FPU_OP_CMP_EQUAL	5'd4
`define FPU_OP_CMP_LESS		5'd5
`define FPU_OP_CMP_LEQUAL	5'd6
`define FPU_OP_MIN			5'd7
`define FPU_OP_MAX			5'd8
`define FPU_OP_F2I			5'd9
`define FPU_OP_I2F			5'd10
`define FPU_OP_UI2F			5'd11

`endif

// ==== hdl/fpu_pkg.sv ====
`include "fpu_defines.svh"

package fpu_pkg;

	// Single precision word, seen as float fields or as a signed integer
	typedef union packed {
		struct packed {
			logic			sign;
			logic [7:0]		exp;
			logic [22:0]	frac;
		} f;
		logic signed [`FPU_XLEN-1:0] i;
	} fpu_word_t;

	// Conversion sequencer
	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		SHIFT,
		DONE
	} fpu_state_t;

endpackage

// ==== hdl/fpu_compare.sv ====
`include "fpu_defines.svh"

`timescale 1ns/10ps

module fpu_compare (
	input  fpu_pkg::fpu_word_t		i_op1,
	input  fpu_pkg::fpu_word_t		i_op2,
	output logic					o_equal,
	output logic					o_less,
	output logic [`FPU_XLEN-1:0]	o_min,
	output logic [`FPU_XLEN-1:0]	o_max
);

	logic nan1;
	logic nan2;
	logic any_nan;
	logic both_zero;
	logic [30:0] mag1;
	logic [30:0] mag2;
	logic lt;

	assign mag1 = {i_op1.f.exp, i_op1.f.frac};
	assign mag2 = {i_op2.f.exp, i_op2.f.frac};

	assign nan1 = (i_op1.f.exp == 8'hff) && (i_op1.f.frac != 23'd0);
	assign nan2 = (i_op2.f.exp == 8'hff) && (i_op2.f.frac != 23'd0);
	assign any_nan = nan1 | nan2;
	assign both_zero = (mag1 == 31'd0) && (mag2 == 31'd0);

	// Sign first, then magnitude; -0 sorts below +0 here
	always_comb begin
		if (i_op1.f.sign != i_op2.f.sign) begin
			lt = i_op1.f.sign;
		end else if (i_op1.f.sign) begin
			lt = mag1 > mag2;	// Both negative
		end else begin
			lt = mag1 < mag2;
		end
	end

	assign o_equal = !any_nan && ((i_op1.i == i_op2.i) || both_zero);
	assign o_less = !any_nan && !both_zero && lt;	// +0 and -0 compare equal

	always_comb begin
		if (nan1 && nan2) begin
			o_min = `FPU_QNAN;
			o_max = `FPU_QNAN;
		end else if (nan1) begin
			o_min = i_op2;	// Lone NaN loses
			o_max = i_op2;
		end else if (nan2) begin
			o_min = i_op1;
			o_max = i_op1;
		end else begin
			o_min = lt ? i_op1 : i_op2;
			o_max = lt ? i_op2 : i_op1;
		end
	end

endmodule

// ==== hdl/fpu_step_counter.sv ====
`timescale 1ns/10ps

module fpu_step_counter (
	input  logic		i_clock,
	input  logic		i_arst_n,
	input  logic		i_load,
	input  logic		i_en,
	input  logic [5:0]	i_steps,
	output logic		o_zero
);

	logic [5:0] count;
	logic [5:0] count_next;

	always_comb begin
		count_next = count;
		if (i_load) begin
			count_next = i_steps;
		end else if (i_en && (count != 6'd0)) begin
			count_next = count - 6'd1;
		end
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			count <= 6'd0;
		end else begin
			count <= count_next;
		end
	end

	// Looks at the count after this edge, so the last shift ends SHIFT
	assign o_zero = (count_next == 6'd0);

endmodule

// ==== hdl/fpu_ctrl.sv ====
`timescale 1ns/10ps

module fpu_ctrl (
	input  logic i_clock,
	input  logic i_arst_n,
	input  logic i_start,
	input  logic i_zero,
	output logic o_load,
	output logic o_cnt_load,
	output logic o_cnt_en,
	output logic o_shift,
	output logic o_finish,
	output logic o_ready
);

	import fpu_pkg::*;

	fpu_state_t state;
	fpu_state_t state_next;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Once started, a conversion runs to DONE whatever i_start does
	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (i_start) begin
					state_next = LOAD;
				end
			end
			LOAD: begin
				state_next = i_zero ? DONE : SHIFT;	// Nothing to shift
			end
			SHIFT: begin
				if (i_zero) begin
					state_next = DONE;
				end
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	assign o_load = (state == LOAD);
	assign o_cnt_load = (state == LOAD);
	assign o_cnt_en = (state == SHIFT);
	assign o_shift = (state == SHIFT);
	assign o_finish = (state == DONE);
	assign o_ready = (state == DONE);	// Single cycle pulse

endmodule

// ==== hdl/fpu_convert.sv ====
`include "fpu_defines.svh"

`timescale 1ns/10ps

module fpu_convert (
	input  logic					i_clock,
	input  logic					i_arst_n,
	input  logic [`FPU_OP_W-1:0]	i_op,
	input  fpu_pkg::fpu_word_t		i_operand,
	input  logic					i_load,
	input  logic					i_shift,
	input  logic					i_finish,
	output logic [5:0]				o_steps,
	output logic [`FPU_XLEN-1:0]	o_result
);

	import fpu_pkg::*;

	logic is_f2i;
	logic int_neg;
	logic [31:0] int_mag;
	logic [23:0] mant;
	logic [5:0] f2i_steps;
	logic [2:0] f2i_lsh;
	logic f2i_q;
	logic sign_q;
	logic sat_q;
	logic nan_q;
	logic zero_q;
	logic [31:0] mag_q;
	logic [7:0] exp_q;
	fpu_word_t res;

	function automatic logic [5:0] lead_zeros(input logic [31:0] v);
		logic [5:0] n;
		logic found;
		n = 6'd0;
		found = 1'b0;
		for (int k = 31; k >= 0; k--) begin
			if (v[k]) begin
				found = 1'b1;
			end else if (!found) begin
				n = n + 6'd1;
			end
		end
		return n;
	endfunction

	assign is_f2i = (i_op == `FPU_OP_F2I);
	assign int_neg = (i_op == `FPU_OP_I2F) && (i_operand.i < 0);
	assign int_mag = int_neg ? -i_operand.i : i_operand.i;
	assign mant = {|i_operand.f.exp, i_operand.f.frac};	// Denormals have no hidden one

	// Right shift by 150 - exp; exponents above 150 are pre-shifted left at load
	always_comb begin
		f2i_lsh = 3'd0;
		if (i_operand.f.exp >= 8'(`FPU_BIAS + 23)) begin
			f2i_steps = 6'd0;
			f2i_lsh = 3'(i_operand.f.exp - 8'(`FPU_BIAS + 23));
		end else if (i_operand.f.exp <= 8'(`FPU_BIAS - 8)) begin
			f2i_steps = 6'd31;
		end else begin
			f2i_steps = 6'(8'(`FPU_BIAS + 23) - i_operand.f.exp);
		end
	end

	always_comb begin
		if (is_f2i) begin
			o_steps = f2i_steps;
		end else if (int_mag == 32'd0) begin
			o_steps = 6'd0;
		end else begin
			o_steps = lead_zeros(int_mag);	// Normalize until bit 31 is set
		end
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			f2i_q <= 1'b0;
			sign_q <= 1'b0;
			sat_q <= 1'b0;
			nan_q <= 1'b0;
			zero_q <= 1'b0;
		end else if (i_load) begin
			f2i_q <= is_f2i;
			sign_q <= is_f2i ? i_operand.f.sign : int_neg;
			sat_q <= i_operand.f.exp >= 8'(`FPU_BIAS + 31);
			nan_q <= (i_operand.f.exp == 8'hff) && (i_operand.f.frac != 23'd0);
			zero_q <= (int_mag == 32'd0);
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_load) begin
			mag_q <= is_f2i ? ({8'd0, mant} << f2i_lsh) : int_mag;
			exp_q <= 8'(`FPU_BIAS + 31);
		end else if (i_shift) begin
			mag_q <= f2i_q ? (mag_q >> 1) : (mag_q << 1);
			exp_q <= exp_q - 8'd1;	// One less per normalizing step
		end
	end

	always_comb begin
		res.i = '0;
		if (i_finish) begin
			if (f2i_q) begin
				if (nan_q) begin
					res.i = 32'h7fffffff;
				end else if (sat_q) begin
					res.i = sign_q ? 32'h80000000 : 32'h7fffffff;
				end else begin
					res.i = sign_q ? -mag_q : mag_q;
				end
			end else if (!zero_q) begin
				res.f.sign = sign_q;
				res.f.exp = exp_q;
				res.f.frac = mag_q[30:8];	// Truncated toward zero
			end
		end
	end

	assign o_result = res;

endmodule

// ==== hdl/fpu.sv ====
`include "fpu_defines.svh"

`timescale 1ns/10ps

module fpu (
	input  logic					i_clock,
	input  logic					i_arst_n,
	input  logic					i_request,
	input  logic [`FPU_OP_W-1:0]	i_op,
	input  logic [`FPU_XLEN-1:0]	i_op1,
	input  logic [`FPU_XLEN-1:0]	i_op2,
	output logic					o_ready,
	output logic [`FPU_XLEN-1:0]	o_result
);

	logic is_conv;
	logic cmp_equal;
	logic cmp_less;
	logic [`FPU_XLEN-1:0] cmp_min;
	logic [`FPU_XLEN-1:0] cmp_max;
	logic cnv_load;
	logic cnt_load;
	logic cnt_en;
	logic cnv_shift;
	logic cnv_finish;
	logic cnv_ready;
	logic cnt_zero;
	logic [5:0] cnv_steps;
	logic [`FPU_XLEN-1:0] cnv_result;

	assign is_conv = (i_op == `FPU_OP_F2I) || (i_op == `FPU_OP_I2F) || (i_op == `FPU_OP_UI2F);

	fpu_compare u_compare (
		.i_op1(i_op1),
		.i_op2(i_op2),
		.o_equal(cmp_equal),
		.o_less(cmp_less),
		.o_min(cmp_min),
		.o_max(cmp_max)
	);

	fpu_ctrl u_ctrl (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_start(i_request & is_conv),
		.i_zero(cnt_zero),
		.o_load(cnv_load),
		.o_cnt_load(cnt_load),
		.o_cnt_en(cnt_en),
		.o_shift(cnv_shift),
		.o_finish(cnv_finish),
		.o_ready(cnv_ready)
	);

	fpu_step_counter u_step_counter (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_load(cnt_load),
		.i_en(cnt_en),
		.i_steps(cnv_steps),
		.o_zero(cnt_zero)
	);

	fpu_convert u_convert (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_op(i_op),
		.i_operand(i_op1),
		.i_load(cnv_load),
		.i_shift(cnv_shift),
		.i_finish(cnv_finish),
		.o_steps(cnv_steps),
		.o_result(cnv_result)
	);

	// Everything but the conversions answers in the request cycle
	assign o_ready = i_request & (is_conv ? cnv_ready : 1'b1);

	always_comb begin
		case (i_op)
			`FPU_OP_MOV:		o_result = i_op1;
			`FPU_OP_SGNJ:		o_result = {i_op2[31], i_op1[30:0]};
			`FPU_OP_SGNJN:		o_result = {~i_op2[31], i_op1[30:0]};
			`FPU_OP_SGNJX:		o_result = {i_op1[31] ^ i_op2[31], i_op1[30:0]};
			`FPU_OP_CMP_EQUAL:	o_result = {31'd0, cmp_equal};
			`FPU_OP_CMP_LESS:	o_result = {31'd0, cmp_less};
			`FPU_OP_CMP_LEQUAL:	o_result = {31'd0, cmp_less | cmp_equal};
			`FPU_OP_MIN:		o_result = cmp_min;
			`FPU_OP_MAX:		o_result = cmp_max;
			`FPU_OP_F2I,
			`FPU_OP_I2F,
			`FPU_OP_UI2F:		o_result = cnv_result;
			default:			o_result = '0;	// Unknown op
		endcase
	end

endmodule

// ==== tb/fpu_checker.sv ====
`timescale 1ns/10ps

module fpu_checker (
	input logic i_clock,
	input logic i_arst_n,
	input logic i_request,
	input logic i_ready,
	input logic i_load,
	input logic i_shift,
	input logic i_finish
);

	logic [5:0] busy_cycles;

	// Cycles spent in LOAD, SHIFT and DONE so far
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			busy_cycles <= 6'd0;
		end else if (i_load | i_shift | i_finish) begin
			busy_cycles <= busy_cycles + 6'd1;
		end else begin
			busy_cycles <= 6'd0;
		end
	end

	// Conversion ready must land while the request is still held
	assert property (@(posedge i_clock) disable iff (!i_arst_n) i_ready |-> i_request)
		else $error("conversion ready high without i_request");

	assert property (@(posedge i_clock) disable iff (!i_arst_n) i_finish |=> !i_finish)
		else $error("controller stayed in DONE for more than one cycle");

	assert property (@(posedge i_clock) disable iff (!i_arst_n) busy_cycles < 6'd36)
		else $error("conversion busy for more than 36 cycles");

	assert property (@(posedge i_clock) !i_arst_n |-> !i_ready)
		else $error("conversion ready high while in reset");

endmodule

bind fpu fpu_checker u_checker (
	.i_clock(i_clock),
	.i_arst_n(i_arst_n),
	.i_request(i_request),
	.i_ready(cnv_ready),
	.i_load(cnv_load),
	.i_shift(cnv_shift),
	.i_finish(cnv_finish)
);

// ==== tb/fpu_tb.sv ====
`include "fpu_defines.svh"

`timescale 1ns/10ps

module fpu_tb;

	localparam int N_RAND = 16;
	localparam int N_MIX = 40;
	// Requests per test, in test order
	localparam int N_REQ = 4*N_RAND + 3*(N_RAND+5) + 2*(N_RAND+6) + 2*(N_RAND+4)
		+ (N_RAND+9) + (N_MIX+2);
	localparam int CYCLE_LIMIT = 40*N_REQ + 100;

	logic i_clock;
	logic i_arst_n;
	logic i_request;
	logic [`FPU_OP_W-1:0] i_op;
	logic [31:0] i_op1;
	logic [31:0] i_op2;
	logic o_ready;
	logic [31:0] o_result;

	logic [31:0] expected_q[$];
	int checks = 0;
	int cmp_errors = 0;
	int seq_errors;
	int issued;
	int last_errors;
	int cycles;

	fpu dut (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_request(i_request),
		.i_op(i_op),
		.i_op1(i_op1),
		.i_op2(i_op2),
		.o_ready(o_ready),
		.o_result(o_result)
	);

	function automatic logic is_nan(input logic [31:0] w);
		return (w[30:23] == 8'hff) && (w[22:0] != 23'd0);
	endfunction

	// Total order used by compare and min/max, -0 below +0
	function automatic logic orders_before(input logic [31:0] a, input logic [31:0] b);
		if (a[31] != b[31]) begin
			return a[31];
		end
		return a[31] ? (a[30:0] > b[30:0]) : (a[30:0] < b[30:0]);
	endfunction

	function automatic logic [31:0] int_to_float(input logic [31:0] v, input logic signed_mode);
		logic neg;
		logic [31:0] m;
		logic [7:0] e;
		neg = signed_mode && v[31];
		m = neg ? (~v + 32'd1) : v;
		e = 8'd158;
		if (m == 32'd0) begin
			return 32'd0;
		end
		while (!m[31]) begin
			m = m << 1;
			e = e - 8'd1;
		end
		return {neg, e, m[30:8]};
	endfunction

	function automatic logic [31:0] float_to_int(input logic [31:0] w);
		logic [7:0] e;
		logic [31:0] m;
		e = w[30:23];
		if (is_nan(w)) begin
			return 32'h7fffffff;
		end else if (e >= 8'd158) begin
			return w[31] ? 32'h80000000 : 32'h7fffffff;
		end else if (e < 8'd127) begin
			return 32'd0;	// Includes zero and denormals
		end
		m = {8'd0, 1'b1, w[22:0]};
		m = (e >= 8'd150) ? (m << (e - 8'd150)) : (m >> (8'd150 - e));
		return w[31] ? (~m + 32'd1) : m;
	endfunction

	function automatic logic [31:0] expected_result(input logic [4:0] op,
			input logic [31:0] a, input logic [31:0] b);
		logic nan;
		logic eq;
		logic lt;
		nan = is_nan(a) || is_nan(b);
		eq = !nan && ((a == b) || ((a[30:0] == 31'd0) && (b[30:0] == 31'd0)));
		lt = !nan && !eq && orders_before(a, b);
		case (op)
			`FPU_OP_MOV: return a;
			`FPU_OP_SGNJ: return {b[31], a[30:0]};
			`FPU_OP_SGNJN: return {~b[31], a[30:0]};
			`FPU_OP_SGNJX: return {a[31] ^ b[31], a[30:0]};
			`FPU_OP_CMP_EQUAL: return {31'd0, eq};
			`FPU_OP_CMP_LESS: return {31'd0, lt};
			`FPU_OP_CMP_LEQUAL: return {31'd0, lt | eq};
			`FPU_OP_MIN, `FPU_OP_MAX: begin
				if (is_nan(a) && is_nan(b)) return `FPU_QNAN;
				if (is_nan(a)) return b;
				if (is_nan(b)) return a;
				return (orders_before(a, b) == (op == `FPU_OP_MIN)) ? a : b;
			end
			`FPU_OP_F2I: return float_to_int(a);
			`FPU_OP_I2F: return int_to_float(a, 1'b1);
			`FPU_OP_UI2F: return int_to_float(a, 1'b0);
			default: return 32'd0;
		endcase
	endfunction

	task automatic check_word(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			$display("mismatch %s exp=%h got=%h", name, expected, actual);
			cmp_errors++;
		end
	endtask

	// Called right after a falling edge; returns after the next one
	task automatic issue(input logic [4:0] op, input logic [31:0] a, input logic [31:0] b);
		int waited;
		logic conv;
		conv = (op == `FPU_OP_F2I) || (op == `FPU_OP_I2F) || (op == `FPU_OP_UI2F);
		expected_q.push_back(expected_result(op, a, b));
		issued++;
		i_request = 1'b1;
		i_op = op;
		i_op1 = a;
		i_op2 = b;
		waited = 0;
		do begin
			@(posedge i_clock);
			waited++;
		end while (!o_ready);
		if ((!conv && waited != 1) || (conv && (waited < 3 || waited > 36))) begin
			$display("op %0d answered after %0d cycles, outside its latency", op, waited);
			seq_errors++;
		end
		@(negedge i_clock);
		i_request = 1'b0;
	endtask

	task automatic issue_compares(input logic [31:0] a, input logic [31:0] b);
		issue(`FPU_OP_CMP_EQUAL, a, b);
		issue(`FPU_OP_CMP_LESS, a, b);
		issue(`FPU_OP_CMP_LEQUAL, a, b);
	endtask

	task automatic issue_min_max(input logic [31:0] a, input logic [31:0] b);
		issue(`FPU_OP_MIN, a, b);
		issue(`FPU_OP_MAX, a, b);
	endtask

	task automatic issue_int_conversions(input logic [31:0] v);
		issue(`FPU_OP_I2F, v, 32'd0);
		issue(`FPU_OP_UI2F, v, 32'd0);
	endtask

	task automatic report_test(input string name);
		$display("test %s: %0d errors", name, seq_errors + cmp_errors - last_errors);
		last_errors = seq_errors + cmp_errors;
	endtask

	initial begin
		i_clock = 1'b0;
		forever #50 i_clock = ~i_clock;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge i_clock);
			cycles++;
		end
		$display("timeout after %0d cycles, a request never completed", cycles);
		$display("TESTS FAILED");
		$finish;
	end

	// Each ready cycle retires the oldest outstanding request
	always @(posedge i_clock) begin
		if (i_arst_n && o_ready) begin
			if (expected_q.size() == 0) begin
				$display("o_ready seen with no request outstanding");
				cmp_errors++;
			end else begin
				check_word("o_result", expected_q.pop_front(), o_result);
			end
		end
	end

	initial begin
		logic [31:0] a;
		int gap;
		void'($urandom(43746));
		seq_errors = 0;
		issued = 0;
		last_errors = 0;
		i_arst_n = 1'b0;
		i_request = 1'b0;
		i_op = '0;
		i_op1 = '0;
		i_op2 = '0;
		repeat (4) @(posedge i_clock);
		@(negedge i_clock);
		i_arst_n = 1'b1;

		for (int n = 0; n < N_RAND; n++) begin
			a = $urandom;
			issue(`FPU_OP_MOV, a, $urandom);
			issue(`FPU_OP_SGNJ, a, $urandom);
			issue(`FPU_OP_SGNJN, a, $urandom);
			issue(`FPU_OP_SGNJX, a, $urandom);
		end
		report_test("move and sign injection");

		for (int n = 0; n < N_RAND; n++) begin
			issue_compares($urandom, $urandom);
		end
		a = $urandom;
		issue_compares(a, a);
		issue_compares(32'h00000000, 32'h80000000);
		issue_compares(32'h80000000, 32'h00000000);
		issue_compares(`FPU_QNAN, a);
		issue_compares(a, 32'hff800001);
		report_test("compare");

		for (int n = 0; n < N_RAND; n++) begin
			issue_min_max($urandom, $urandom);
		end
		issue_min_max(32'h80000000, 32'h00000000);
		issue_min_max(32'h00000000, 32'h80000000);
		issue_min_max(`FPU_QNAN, a);
		issue_min_max(a, 32'h7f800123);
		issue_min_max(`FPU_QNAN, 32'hffc00000);
		issue_min_max(a, a);
		report_test("min and max");

		for (int n = 0; n < N_RAND; n++) begin
			issue_int_conversions($urandom);
		end
		issue_int_conversions(32'h00000000);
		issue_int_conversions(32'h00000001);
		issue_int_conversions(32'h80000000);
		issue_int_conversions(32'hffffffff);
		report_test("integer to float");

		for (int n = 0; n < N_RAND; n++) begin
			a = $urandom;
			a[30:23] = 8'(127 + $urandom % 31);	// Magnitude fits in 31 bits
			issue(`FPU_OP_F2I, a, 32'd0);
		end
		issue(`FPU_OP_F2I, 32'h3f7fffff, 32'd0);
		issue(`FPU_OP_F2I, 32'hb2000001, 32'd0);
		issue(`FPU_OP_F2I, 32'h4f000000, 32'd0);
		issue(`FPU_OP_F2I, 32'he4000000, 32'd0);
		issue(`FPU_OP_F2I, 32'h7f800000, 32'd0);
		issue(`FPU_OP_F2I, 32'hff800000, 32'd0);
		issue(`FPU_OP_F2I, `FPU_QNAN, 32'd0);
		issue(`FPU_OP_F2I, 32'hffc00001, 32'd0);
		issue(`FPU_OP_F2I, 32'h00000123, 32'd0);
		report_test("float to integer");

		// Conversion directly behind a single-cycle op
		issue(`FPU_OP_MOV, $urandom, $urandom);
		issue(`FPU_OP_I2F, $urandom, 32'd0);
		for (int n = 0; n < N_MIX; n++) begin
			gap = $urandom % 4;
			repeat (gap) @(negedge i_clock);
			issue(5'($urandom % 14), $urandom, $urandom);	// 12 and 13 are unknown codes
		end
		report_test("mixed back to back");

		repeat (2) @(negedge i_clock);
		if (expected_q.size() != 0 || checks != issued) begin
			$display("%0d requests issued but %0d results seen", issued, checks);
			seq_errors++;
		end
		$display("%0d requests, %0d checks, %0d errors", issued, checks,
			seq_errors + cmp_errors);
		if (seq_errors + cmp_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+include
hdl/fpu_pkg.sv
hdl/fpu_compare.sv
hdl/fpu_step_counter.sv
hdl/fpu_ctrl.sv
hdl/fpu_convert.sv
hdl/fpu.sv
tb/fpu_checker.sv
tb/fpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module fpu_tb -Mdir obj_dir -o fpu_sim -f vlog.f

./obj_dir/fpu_sim | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1
